//--- list.f
+incdir+include
src/slam_pkg.sv
src/plb_state_ram.sv
src/plb_seq_ctrl.sv
src/plb_din_map.sv
src/slam_apb_regs.sv
src/slam_backend_top.sv
tests/tb_clk_gen.sv
tests/slam_backend_chk.sv
tests/tb_slam_backend.sv

//--- tests/slam_vectors.txt
# op P addr data | D,B row d0 d1 d2 d3 | R addr expected | C | K row chi | X addr
# S status landmark, status 0 wait 1 new 2 upd 3 fail | all values hex
S 0 0
P 00b a5a5a5a5
P 00c 00000010
P 00d 7fffffff
P 00e 80000000
P 00f 12345678
P 010 5a5a5a5a
D 3 00000005 00000001 ffffffff fffffff0
R 00c 00000015
R 00d 80000000
R 00e 7fffffff
R 00f 12345668
B 3 00000100 00000200 00000300 00000400
R 00c 00000115
R 00d 80000200
R 00e 800002ff
R 00f 12345a68
R 00b a5a5a5a5
R 010 5a5a5a5a
C
K 5 00400000
K 7 00100000
K 9 00100000
S 2 7
C
K 1 00800000
K 6 7fff0000
S 1 1
K 4 00500000
S 3 4
C
S 0 0
X 2c
X 0a

//--- tests/tb_slam_backend.sv
`timescale 1ns/1ps
`default_nettype none

`include "slam_params.svh"

module tb_slam_backend;

  localparam int RST_CYCLES   = 4;
  localparam int CYCLE_BUDGET = 40;  // per vector
  localparam int MAX_VEC      = 64;

  localparam logic [`APB_AW-1:0] A_CMD      = 'h00;
  localparam logic [`APB_AW-1:0] A_STATUS   = 'h04;
  localparam logic [`APB_AW-1:0] A_DELTA0   = 'h08;
  localparam logic [`APB_AW-1:0] A_DELTA1   = 'h0c;
  localparam logic [`APB_AW-1:0] A_DELTA2   = 'h10;
  localparam logic [`APB_AW-1:0] A_DELTA3   = 'h14;
  localparam logic [`APB_AW-1:0] A_LANDMARK = 'h18;
  localparam logic [`APB_AW-1:0] A_CHI      = 'h1c;
  localparam logic [`APB_AW-1:0] A_MEM_ADDR = 'h20;
  localparam logic [`APB_AW-1:0] A_MEM_DATA = 'h24;

  logic                clk;
  logic                sys_rst;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [`APB_AW-1:0]  paddr;
  logic [`RSA_DW-1:0]  pwdata;
  logic [`RSA_DW-1:0]  prdata;
  logic                pready;
  logic                pslverr;

  logic [7:0]          vec_op  [MAX_VEC];
  logic [31:0]         vec_arg [MAX_VEC][5];
  int                  num_vec = 0;
  int                  timeout_limit = 0;
  int                  cycle_cnt = 0;

  tb_clk_gen #(.PERIOD_NS(100), .RST_CYCLES(RST_CYCLES)) i_tb_clk_gen (
    .o_clk     (clk),
    .o_sys_rst (sys_rst)
  );

  slam_backend_top i_slam_backend_top (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata),
    .o_pready  (pready),
    .o_pslverr (pslverr)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [31:0] data,
                           output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1 penable = 1'b1;
    @(negedge clk);
    err = pslverr;
    check("apb write pready", 32'd1, {31'd0, pready});
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [`APB_AW-1:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge clk);
    #1;
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    @(posedge clk);
    #1 penable = 1'b1;
    @(negedge clk);  // mid access phase
    data = prdata;
    err  = pslverr;
    check("apb read pready", 32'd1, {31'd0, pready});
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    logic        err;
    st = 32'h1;
    while (st[0]) apb_read(A_STATUS, st, err);
  endtask

  function automatic int arg_count(input logic [7:0] op);
    case (op)
      "P", "R", "K", "S": return 2;
      "D", "B":           return 5;
      "X":                return 1;
      "C":                return 0;
      default:            return -1;
    endcase
  endfunction

  task automatic load_vectors();
    integer             fd;
    integer             n;
    int                 nargs;
    logic [63:0]        op;
    logic [31:0]        val;
    logic [8*256-1:0]   line;
    fd = $fopen("tests/slam_vectors.txt", "r");
    if (fd == 0) abort_run("cannot open tests/slam_vectors.txt");
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        n = $fgets(line, fd);  // skip comment text
      end else begin
        nargs = arg_count(op[7:0]);
        if (nargs < 0) abort_run("unknown op code in vector file");
        vec_op[num_vec] = op[7:0];
        for (int k = 0; k < 5; k++) begin
          val = '0;
          if (k < nargs) n = $fscanf(fd, "%h", val);
          vec_arg[num_vec][k] = val;
        end
        num_vec = num_vec + 1;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_vector(input int idx);
    logic [31:0] rd;
    logic        err;
    string       name;
    name = $sformatf("vector %0d (%s)", idx, vec_op[idx]);
    case (vec_op[idx])
      "P": begin
        apb_write(A_MEM_ADDR, vec_arg[idx][0], err);
        apb_write(A_MEM_DATA, vec_arg[idx][1], err);
      end
      "D", "B": begin
        apb_write(A_DELTA0, vec_arg[idx][1], err);
        apb_write(A_DELTA1, vec_arg[idx][2], err);
        apb_write(A_DELTA2, vec_arg[idx][3], err);
        apb_write(A_DELTA3, vec_arg[idx][4], err);
        apb_write(A_LANDMARK, vec_arg[idx][0], err);
        apb_write(A_CMD, 32'h1, err);
        check({name, " start"}, 32'd0, {31'd0, err});
        if (vec_op[idx] == "B") begin
          apb_write(A_CMD, 32'h1, err);  // must be rejected
          check({name, " command while busy"}, 32'd1, {31'd0, err});
        end
        wait_idle();
      end
      "R": begin
        apb_write(A_MEM_ADDR, vec_arg[idx][0], err);
        apb_read(A_MEM_DATA, rd, err);
        check(name, vec_arg[idx][1], rd);
      end
      "C": begin
        apb_write(A_CMD, 32'h2, err);
        wait_idle();
      end
      "K": begin
        apb_write(A_LANDMARK, vec_arg[idx][0], err);
        apb_write(A_CHI, vec_arg[idx][1], err);
        wait_idle();
      end
      "S": begin
        apb_read(A_STATUS, rd, err);
        // landmark at 17:8, status at 2:1, busy 0
        check(name, (vec_arg[idx][1] << 8) | (vec_arg[idx][0] << 1), rd);
      end
      "X": begin
        apb_read(vec_arg[idx][0][`APB_AW-1:0], rd, err);
        check({name, " read error"}, 32'd1, {31'd0, err});
        apb_write(vec_arg[idx][0][`APB_AW-1:0], 32'h0, err);
        check({name, " write error"}, 32'd1, {31'd0, err});
      end
      default: abort_run("unexpected op code while running vectors");
    endcase
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if ((timeout_limit != 0) && (cycle_cnt >= timeout_limit)) begin
      abort_run("timeout: test did not finish");
    end
  end

  always @(posedge clk) begin
    if (i_slam_backend_top.i_plb_din_map.i_slam_backend_chk.fail_count != 0) begin
      abort_run("assertion on the engine memory port failed");
    end
  end

  initial begin
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    load_vectors();
    timeout_limit = num_vec * CYCLE_BUDGET + RST_CYCLES;
    @(negedge sys_rst);
    for (int i = 0; i < num_vec; i++) run_vector(i);
    @(posedge clk);
    if (i_slam_backend_top.i_plb_din_map.i_slam_backend_chk.fail_count != 0) begin
      abort_run("assertion on the engine memory port failed");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tests/slam_backend_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "slam_params.svh"

module slam_backend_chk (
  input wire                clk,
  input wire                sys_rst,
  input wire                i_plb_en,
  input wire                i_plb_we,
  input wire [`PLB_AW-1:0]  i_plb_addr,
  input wire [`ROW_LEN-1:0] i_l_k
);

  logic [`PLB_AW-1:0] base;
  int                 fail_count = 0;

  assign base = `PLB_AW'({i_l_k, 2'b00});

  en_low_after_reset: assert property (@(posedge clk) sys_rst |=> !i_plb_en)
    else begin
      fail_count = fail_count + 1;
      $error("port A enabled right after reset");
    end

  we_needs_en: assert property (@(posedge clk) disable iff (sys_rst) i_plb_we |-> i_plb_en)
    else begin
      fail_count = fail_count + 1;
      $error("port A write without enable");
    end

  // row has four words
  addr_in_row: assert property (@(posedge clk) disable iff (sys_rst)
    i_plb_en |-> ((i_plb_addr >= base) && (i_plb_addr <= base + 3)))
    else begin
      fail_count = fail_count + 1;
      $error("port A address outside the landmark row");
    end

endmodule

bind plb_din_map slam_backend_chk i_slam_backend_chk (
  .clk        (clk),
  .sys_rst    (sys_rst),
  .i_plb_en   (o_plb_en),
  .i_plb_we   (o_plb_we),
  .i_plb_addr (o_plb_addr),
  .i_l_k      (i_l_k)
);

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 4
) (
  output logic o_clk,
  output logic o_sys_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    o_sys_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    #1 o_sys_rst = 1'b0;  // released just after an edge like other inputs
  end

endmodule

`default_nettype wire

//--- src/slam_backend_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "slam_params.svh"

module slam_backend_top (
  input  wire                  clk,
  input  wire                  sys_rst,
  input  wire                  i_psel,
  input  wire                  i_penable,
  input  wire                  i_pwrite,
  input  wire [`APB_AW-1:0]    i_paddr,
  input  wire [`RSA_DW-1:0]    i_pwdata,
  output logic [`RSA_DW-1:0]   o_prdata,
  output logic                 o_pready,
  output logic                 o_pslverr
);

  logic                    upd_start;
  logic                    assoc_clr;
  logic                    chi_valid;
  logic                    busy;
  slam_pkg::phase_t        phase;
  slam_pkg::seq_cnt_t      seq_cnt;
  slam_pkg::word_t         delta0;
  slam_pkg::word_t         delta1;
  slam_pkg::word_t         delta2;
  slam_pkg::word_t         delta3;
  slam_pkg::word_t         chi;
  logic [`ROW_LEN-1:0]     l_k;
  slam_pkg::assoc_status_t assoc_status;
  logic [`ROW_LEN-1:0]     assoc_l_k;
  logic                    plb_en;
  logic                    plb_we;
  logic [`PLB_AW-1:0]      plb_addr;
  slam_pkg::word_t         plb_din;
  slam_pkg::word_t         plb_dout;
  logic                    mem_we;
  logic [`PLB_AW-1:0]      mem_addr;
  slam_pkg::word_t         mem_din;
  slam_pkg::word_t         mem_dout;

  slam_apb_regs i_slam_apb_regs (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_psel         (i_psel),
    .i_penable      (i_penable),
    .i_pwrite       (i_pwrite),
    .i_paddr        (i_paddr),
    .i_pwdata       (i_pwdata),
    .o_prdata       (o_prdata),
    .o_pready       (o_pready),
    .o_pslverr      (o_pslverr),
    .i_busy         (busy),
    .i_assoc_status (assoc_status),
    .i_assoc_l_k    (assoc_l_k),
    .o_upd_start    (upd_start),
    .o_assoc_clr    (assoc_clr),
    .o_chi_valid    (chi_valid),
    .o_delta0       (delta0),
    .o_delta1       (delta1),
    .o_delta2       (delta2),
    .o_delta3       (delta3),
    .o_l_k          (l_k),
    .o_chi          (chi),
    .o_mem_we       (mem_we),
    .o_mem_addr     (mem_addr),
    .o_mem_din      (mem_din),
    .i_mem_dout     (mem_dout)
  );

  plb_seq_ctrl i_plb_seq_ctrl (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_upd_start (upd_start),
    .i_assoc_clr (assoc_clr),
    .i_chi_valid (chi_valid),
    .o_phase     (phase),
    .o_seq_cnt   (seq_cnt),
    .o_busy      (busy)
  );

  plb_din_map i_plb_din_map (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_phase        (phase),
    .i_seq_cnt      (seq_cnt),
    .i_l_k          (l_k),
    .i_delta0       (delta0),
    .i_delta1       (delta1),
    .i_delta2       (delta2),
    .i_delta3       (delta3),
    .i_chi          (chi),
    .i_plb_dout     (plb_dout),
    .o_plb_en       (plb_en),
    .o_plb_we       (plb_we),
    .o_plb_addr     (plb_addr),
    .o_plb_din      (plb_din),
    .o_assoc_status (assoc_status),
    .o_assoc_l_k    (assoc_l_k)
  );

  plb_state_ram i_plb_state_ram (
    .clk      (clk),
    .i_a_en   (plb_en),
    .i_a_we   (plb_we),
    .i_a_addr (plb_addr),
    .i_a_din  (plb_din),
    .o_a_dout (plb_dout),
    .i_b_we   (mem_we),
    .i_b_addr (mem_addr),
    .i_b_din  (mem_din),
    .o_b_dout (mem_dout)
  );

endmodule

`default_nettype wire

//--- src/slam_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "slam_params.svh"

module slam_apb_regs (
  input  wire                            clk,
  input  wire                            sys_rst,
  input  wire                            i_psel,
  input  wire                            i_penable,
  input  wire                            i_pwrite,
  input  wire [`APB_AW-1:0]              i_paddr,
  input  wire [`RSA_DW-1:0]              i_pwdata,
  output logic [`RSA_DW-1:0]             o_prdata,
  output logic                           o_pready,
  output logic                           o_pslverr,
  input  wire                            i_busy,
  input  wire slam_pkg::assoc_status_t   i_assoc_status,
  input  wire [`ROW_LEN-1:0]             i_assoc_l_k,
  output logic                           o_upd_start,
  output logic                           o_assoc_clr,
  output logic                           o_chi_valid,
  output slam_pkg::word_t                o_delta0,
  output slam_pkg::word_t                o_delta1,
  output slam_pkg::word_t                o_delta2,
  output slam_pkg::word_t                o_delta3,
  output logic [`ROW_LEN-1:0]            o_l_k,
  output slam_pkg::word_t                o_chi,
  output logic                           o_mem_we,
  output logic [`PLB_AW-1:0]             o_mem_addr,
  output slam_pkg::word_t                o_mem_din,
  input  wire slam_pkg::word_t           i_mem_dout
);

  localparam logic [`APB_AW-1:0] A_CMD      = 'h00;
  localparam logic [`APB_AW-1:0] A_STATUS   = 'h04;
  localparam logic [`APB_AW-1:0] A_DELTA0   = 'h08;
  localparam logic [`APB_AW-1:0] A_DELTA1   = 'h0c;
  localparam logic [`APB_AW-1:0] A_DELTA2   = 'h10;
  localparam logic [`APB_AW-1:0] A_DELTA3   = 'h14;
  localparam logic [`APB_AW-1:0] A_LANDMARK = 'h18;
  localparam logic [`APB_AW-1:0] A_CHI      = 'h1c;
  localparam logic [`APB_AW-1:0] A_MEM_ADDR = 'h20;
  localparam logic [`APB_AW-1:0] A_MEM_DATA = 'h24;

  logic apb_wr;
  logic mapped;
  logic cmd_hit;
  logic cmd_ok;

  assign apb_wr  = i_psel && i_penable && i_pwrite;
  assign mapped  = (i_paddr[1:0] == 2'b00) && (i_paddr <= A_MEM_DATA);
  assign cmd_hit = apb_wr && ((i_paddr == A_CMD) || (i_paddr == A_CHI));
  assign cmd_ok  = cmd_hit && !i_busy;

  assign o_pready  = 1'b1;  // no wait states
  assign o_pslverr = i_psel && i_penable && (!mapped || (cmd_hit && i_busy));

  // command pulses, one access phase wide
  assign o_upd_start = cmd_ok && (i_paddr == A_CMD) && i_pwdata[0];
  assign o_assoc_clr = cmd_ok && (i_paddr == A_CMD) && i_pwdata[1];
  assign o_chi_valid = cmd_ok && (i_paddr == A_CHI);

  assign o_mem_we  = apb_wr && (i_paddr == A_MEM_DATA);
  assign o_mem_din = i_pwdata;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_delta0   <= '0;
      o_delta1   <= '0;
      o_delta2   <= '0;
      o_delta3   <= '0;
      o_l_k      <= '0;
      o_chi      <= '0;
      o_mem_addr <= '0;
    end else if (apb_wr) begin
      case (i_paddr)
        A_DELTA0:   o_delta0   <= i_pwdata;
        A_DELTA1:   o_delta1   <= i_pwdata;
        A_DELTA2:   o_delta2   <= i_pwdata;
        A_DELTA3:   o_delta3   <= i_pwdata;
        A_LANDMARK: o_l_k      <= i_pwdata[`ROW_LEN-1:0];
        A_CHI:      if (!i_busy) o_chi <= i_pwdata;
        A_MEM_ADDR: o_mem_addr <= i_pwdata[`PLB_AW-1:0];
        default:    ;
      endcase
    end
  end

  always_comb begin
    case (i_paddr)
      A_STATUS: o_prdata = {{(`RSA_DW-`ROW_LEN-8){1'b0}}, i_assoc_l_k,
                            5'd0, i_assoc_status, i_busy};
      A_DELTA0:   o_prdata = o_delta0;
      A_DELTA1:   o_prdata = o_delta1;
      A_DELTA2:   o_prdata = o_delta2;
      A_DELTA3:   o_prdata = o_delta3;
      A_LANDMARK: o_prdata = `RSA_DW'(o_l_k);
      A_CHI:      o_prdata = o_chi;
      A_MEM_ADDR: o_prdata = `RSA_DW'(o_mem_addr);
      A_MEM_DATA: o_prdata = i_mem_dout;  // read issued during setup
      default:    o_prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/plb_din_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "slam_params.svh"

module plb_din_map (
  input  wire                         clk,
  input  wire                         sys_rst,
  input  wire slam_pkg::phase_t       i_phase,
  input  wire slam_pkg::seq_cnt_t     i_seq_cnt,
  input  wire [`ROW_LEN-1:0]          i_l_k,
  input  wire slam_pkg::word_t        i_delta0,
  input  wire slam_pkg::word_t        i_delta1,
  input  wire slam_pkg::word_t        i_delta2,
  input  wire slam_pkg::word_t        i_delta3,
  input  wire slam_pkg::word_t        i_chi,
  input  wire slam_pkg::word_t        i_plb_dout,
  output logic                        o_plb_en,
  output logic                        o_plb_we,
  output logic [`PLB_AW-1:0]          o_plb_addr,
  output slam_pkg::word_t             o_plb_din,
  output slam_pkg::assoc_status_t     o_assoc_status,
  output logic [`ROW_LEN-1:0]         o_assoc_l_k
);

  localparam slam_pkg::seq_cnt_t SEQ_9  = `SEQ_CNT_DW'(9);
  localparam slam_pkg::seq_cnt_t SEQ_10 = `SEQ_CNT_DW'(10);

  localparam slam_pkg::word_t CHI_MAX = {1'b0, {(`RSA_DW-1){1'b1}}};
  localparam slam_pkg::word_t CHI_95  = `CHI_95;
  localparam slam_pkg::word_t CHI_999 = `CHI_999;

  slam_pkg::word_t delta [`X];
  slam_pkg::word_t sum   [`X];

  logic [`PLB_AW-1:0] base;
  logic               upd_step;
  logic [1:0]         rd_idx;

  assign delta[0] = i_delta0;
  assign delta[1] = i_delta1;
  assign delta[2] = i_delta2;
  assign delta[3] = i_delta3;

  assign base     = `PLB_AW'({i_l_k, 2'b00});  // four words per row
  assign upd_step = (i_phase == slam_pkg::PH_UPD) && (i_seq_cnt < `SEQ_CNT_DW'(8));
  assign rd_idx   = i_seq_cnt[1:0] - 2'd1;     // word whose data is on dout

  // port A control, steps 0-3 read and 4-7 write
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_plb_en   <= 1'b0;
      o_plb_we   <= 1'b0;
      o_plb_addr <= '0;
    end else if (upd_step) begin
      o_plb_en   <= 1'b1;
      o_plb_we   <= i_seq_cnt[2];
      o_plb_addr <= base + `PLB_AW'(i_seq_cnt[1:0]);
    end else begin
      o_plb_en <= 1'b0;
      o_plb_we <= 1'b0;
    end
  end

  // sums land in steps 1-4, write data follows in 4-7
  always_ff @(posedge clk) begin
    if (upd_step) begin
      if ((i_seq_cnt != '0) && (i_seq_cnt <= `SEQ_CNT_DW'(4))) begin
        sum[rd_idx] <= i_plb_dout + delta[rd_idx];  // wraps at word width
      end
      if (i_seq_cnt[2]) begin
        o_plb_din <= sum[i_seq_cnt[1:0]];
      end
    end
  end

  slam_pkg::word_t     temp_chi;
  logic [`ROW_LEN-1:0] temp_l_k;
  slam_pkg::word_t     min_chi;
  logic                have_cand;

  always_ff @(posedge clk) begin
    if ((i_phase == slam_pkg::PH_ASSOC) && (i_seq_cnt == SEQ_9)) begin
      temp_chi <= i_chi;
      temp_l_k <= i_l_k;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst || (i_phase == slam_pkg::PH_ASSOC_CLR)) begin
      min_chi        <= CHI_MAX;
      have_cand      <= 1'b0;
      o_assoc_l_k    <= '0;
      o_assoc_status <= slam_pkg::ASSOC_WAIT;
    end else begin
      if ((i_phase == slam_pkg::PH_ASSOC) && (i_seq_cnt == SEQ_10)) begin
        have_cand <= 1'b1;
        if (temp_chi < min_chi) begin  // strictly smaller only
          min_chi     <= temp_chi;
          o_assoc_l_k <= temp_l_k;
        end
      end
      if (have_cand) begin
        if (min_chi < CHI_95) begin
          o_assoc_status <= slam_pkg::ASSOC_UPD;
        end else if (min_chi > CHI_999) begin
          o_assoc_status <= slam_pkg::ASSOC_NEW;
        end else begin
          o_assoc_status <= slam_pkg::ASSOC_FAIL;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/plb_seq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "slam_params.svh"

module plb_seq_ctrl (
  input  wire                  clk,
  input  wire                  sys_rst,
  input  wire                  i_upd_start,
  input  wire                  i_assoc_clr,
  input  wire                  i_chi_valid,
  output slam_pkg::phase_t     o_phase,
  output slam_pkg::seq_cnt_t   o_seq_cnt,
  output logic                 o_busy
);

  localparam slam_pkg::seq_cnt_t UPD_LAST    = `SEQ_CNT_DW'(7);
  localparam slam_pkg::seq_cnt_t ASSOC_FIRST = `SEQ_CNT_DW'(9);
  localparam slam_pkg::seq_cnt_t ASSOC_LAST  = `SEQ_CNT_DW'(10);

  logic drain;  // extra cycle while the engine finishes its last action

  assign o_busy = (o_phase != slam_pkg::PH_IDLE) || drain;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_phase   <= slam_pkg::PH_IDLE;
      o_seq_cnt <= '0;
      drain     <= 1'b0;
    end else begin
      drain <= ((o_phase == slam_pkg::PH_UPD) && (o_seq_cnt == UPD_LAST)) ||
               ((o_phase == slam_pkg::PH_ASSOC) && (o_seq_cnt == ASSOC_LAST));
      case (o_phase)
        slam_pkg::PH_IDLE: begin
          if (!drain) begin
            if (i_upd_start) begin
              o_phase   <= slam_pkg::PH_UPD;
              o_seq_cnt <= '0;
            end else if (i_assoc_clr) begin
              o_phase   <= slam_pkg::PH_ASSOC_CLR;
              o_seq_cnt <= '0;
            end else if (i_chi_valid) begin
              o_phase   <= slam_pkg::PH_ASSOC;
              o_seq_cnt <= ASSOC_FIRST;
            end
          end
        end
        slam_pkg::PH_UPD: begin
          if (o_seq_cnt == UPD_LAST) begin
            o_phase   <= slam_pkg::PH_IDLE;
            o_seq_cnt <= '0;
          end else begin
            o_seq_cnt <= o_seq_cnt + 1'b1;
          end
        end
        slam_pkg::PH_ASSOC: begin
          if (o_seq_cnt == ASSOC_LAST) begin
            o_phase   <= slam_pkg::PH_IDLE;
            o_seq_cnt <= '0;
          end else begin
            o_seq_cnt <= o_seq_cnt + 1'b1;
          end
        end
        default: begin  // clear lasts one cycle
          o_phase   <= slam_pkg::PH_IDLE;
          o_seq_cnt <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/plb_state_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "slam_params.svh"

module plb_state_ram (
  input  wire                     clk,
  // port A, update engine
  input  wire                     i_a_en,
  input  wire                     i_a_we,
  input  wire [`PLB_AW-1:0]       i_a_addr,
  input  wire slam_pkg::word_t    i_a_din,
  output slam_pkg::word_t         o_a_dout,
  // port B, host
  input  wire                     i_b_we,
  input  wire [`PLB_AW-1:0]       i_b_addr,
  input  wire slam_pkg::word_t    i_b_din,
  output slam_pkg::word_t         o_b_dout
);

  slam_pkg::word_t mem [2**`PLB_AW];

  assign o_a_dout = mem[i_a_addr];  // async read, engine adds next step

  always_ff @(posedge clk) begin
    if (i_a_en && i_a_we) begin
      mem[i_a_addr] <= i_a_din;
    end
    if (i_b_we) begin
      mem[i_b_addr] <= i_b_din;
    end
    o_b_dout <= mem[i_b_addr];
  end

endmodule

`default_nettype wire

//--- src/slam_pkg.sv
`default_nettype none

`include "slam_params.svh"

package slam_pkg;

  typedef logic signed [`RSA_DW-1:0] word_t;  // state or chi word

  typedef logic [`SEQ_CNT_DW-1:0] seq_cnt_t;

  typedef enum logic [1:0] {
    PH_IDLE      = 2'd0,
    PH_UPD       = 2'd1,
    PH_ASSOC_CLR = 2'd2,
    PH_ASSOC     = 2'd3
  } phase_t;

  typedef enum logic [1:0] {
    ASSOC_WAIT = 2'b00,
    ASSOC_NEW  = 2'b01,
    ASSOC_UPD  = 2'b10,
    ASSOC_FAIL = 2'b11
  } assoc_status_t;

endpackage

`default_nettype wire

//--- include/slam_params.svh
`ifndef SLAM_PARAMS_SVH
`define SLAM_PARAMS_SVH

// datapath
`define RSA_DW      32
`define X           4   // words per landmark row
`define PLB_AW      10
`define ROW_LEN     10
`define SEQ_CNT_DW  5

// host bus
`define APB_AW      8

// chi-square gate, fixed point
`define CHI_95      32'h002f_ee87  // 5.99147
`define CHI_999     32'h006e_8625  // 13.8155

`endif
